// ==== source/llc_pkg.sv ====
`default_nettype none

package llc_pkg;

    // cache geometry
    localparam int LLC_WAYS = 4;
    localparam int LLC_SET_BITS = 4;
    localparam int LLC_SETS = 1 << LLC_SET_BITS;
    localparam int LLC_WAY_BITS = $clog2(LLC_WAYS);

    // field widths
    localparam int LLC_TAG_BITS = 12;
    localparam int LLC_LINE_BITS = 64;
    localparam int LLC_SHARERS_BITS = 4;
    localparam int LLC_STATE_BITS = 3;

    typedef logic [LLC_SET_BITS-1:0] llc_set_t;
    typedef logic [LLC_WAY_BITS-1:0] llc_way_t;
    typedef logic [LLC_TAG_BITS-1:0] llc_tag_t;
    typedef logic [LLC_LINE_BITS-1:0] line_t;

    // one bit per requester that may hold a copy of the line
    typedef logic [LLC_SHARERS_BITS-1:0] sharers_t;

    // coherence state of a cached line, invalid must stay zero
    typedef enum logic [LLC_STATE_BITS-1:0] {
        LLC_INVALID   = 3'd0,
        LLC_VALID     = 3'd1,
        LLC_SHARED    = 3'd2,
        LLC_EXCLUSIVE = 3'd3,
        LLC_MODIFIED  = 3'd4
    } llc_state_t;

endpackage

`default_nettype wire

// ==== source/llc_sync_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module llc_sync_ram #(
    parameter int WIDTH = 8,
    parameter int DEPTH_BITS = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // write port
    input  logic                  we,
    input  logic [DEPTH_BITS-1:0] waddr,
    input  logic [WIDTH-1:0]      wdata,

    // read port
    input  logic                  re,
    input  logic [DEPTH_BITS-1:0] raddr,
    output logic [WIDTH-1:0]      rdata
);

    localparam int DEPTH = 1 << DEPTH_BITS;

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, sees the array before a write on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (re) begin
            rdata <= mem[raddr];
        end
    end

    // a write with an unknown address would corrupt an arbitrary entry
    a_waddr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        we |-> !$isunknown(waddr)
    ) else $error("llc_sync_ram: write address unknown while we is high");

endmodule

`default_nettype wire

// ==== source/llc_way_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module llc_way_store
    import llc_pkg::*;
#(
    parameter int WAY_INDEX = 0
) (
    input  logic       clk,
    input  logic       rst_n,

    input  llc_set_t   set_in,
    input  llc_way_t   way,
    input  logic       wr_en,
    input  logic       flush,
    input  logic       rd_en,

    input  llc_tag_t   wr_data_tag,
    input  line_t      wr_data_line,
    input  llc_state_t wr_data_state,
    input  logic       wr_data_dirty_bit,
    input  sharers_t   wr_data_sharers,

    output llc_tag_t   rd_data_tag,
    output line_t      rd_data_line,
    output llc_state_t rd_data_state,
    output logic       rd_data_dirty_bit,
    output sharers_t   rd_data_sharers
);

    logic way_hit;
    logic field_en;
    logic flush_field_en;

    logic [LLC_STATE_BITS-1:0] state_wbits;
    logic [LLC_STATE_BITS-1:0] state_rbits;

    assign way_hit = (way == llc_way_t'(WAY_INDEX));

    // tag and line only change on a regular write to this way
    assign field_en = wr_en & way_hit;

    // state, dirty and sharers are also cleared by a flush of this way
    // while another way takes the regular write
    assign flush_field_en = field_en | (flush & ~way_hit);

    // state memory stores raw bits
    assign state_wbits = wr_data_state;
    assign rd_data_state = llc_state_t'(state_rbits);

    llc_sync_ram #(
        .WIDTH(LLC_TAG_BITS),
        .DEPTH_BITS(LLC_SET_BITS)
    ) tag_ram_inst (
        .clk(clk),
        .rst_n(rst_n),
        .we(field_en),
        .waddr(set_in),
        .wdata(wr_data_tag),
        .re(rd_en),
        .raddr(set_in),
        .rdata(rd_data_tag)
    );

    llc_sync_ram #(
        .WIDTH(LLC_LINE_BITS),
        .DEPTH_BITS(LLC_SET_BITS)
    ) line_ram_inst (
        .clk(clk),
        .rst_n(rst_n),
        .we(field_en),
        .waddr(set_in),
        .wdata(wr_data_line),
        .re(rd_en),
        .raddr(set_in),
        .rdata(rd_data_line)
    );

    llc_sync_ram #(
        .WIDTH(LLC_STATE_BITS),
        .DEPTH_BITS(LLC_SET_BITS)
    ) state_ram_inst (
        .clk(clk),
        .rst_n(rst_n),
        .we(flush_field_en),
        .waddr(set_in),
        .wdata(state_wbits),
        .re(rd_en),
        .raddr(set_in),
        .rdata(state_rbits)
    );

    llc_sync_ram #(
        .WIDTH(1),
        .DEPTH_BITS(LLC_SET_BITS)
    ) dirty_ram_inst (
        .clk(clk),
        .rst_n(rst_n),
        .we(flush_field_en),
        .waddr(set_in),
        .wdata(wr_data_dirty_bit),
        .re(rd_en),
        .raddr(set_in),
        .rdata(rd_data_dirty_bit)
    );

    llc_sync_ram #(
        .WIDTH(LLC_SHARERS_BITS),
        .DEPTH_BITS(LLC_SET_BITS)
    ) sharers_ram_inst (
        .clk(clk),
        .rst_n(rst_n),
        .we(flush_field_en),
        .waddr(set_in),
        .wdata(wr_data_sharers),
        .re(rd_en),
        .raddr(set_in),
        .rdata(rd_data_sharers)
    );

    // the state read back must be one the controller could have written;
    // sets never flushed read unknown in a four-state simulator
    a_state_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(state_rbits) |->
            state_rbits inside {LLC_INVALID, LLC_VALID, LLC_SHARED,
                                LLC_EXCLUSIVE, LLC_MODIFIED}
    ) else $error("llc_way_store %0d: illegal state encoding %0d read back",
                  WAY_INDEX, state_rbits);

endmodule

`default_nettype wire

// ==== source/llc_localmem.sv ====
`timescale 1ns/10ps
`default_nettype none

module llc_localmem
    import llc_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,

    // access control
    input  llc_set_t            set_in,
    input  llc_way_t            way,
    input  logic                rd_en,
    input  logic                wr_en,
    input  logic [LLC_WAYS-1:0] wr_rst_flush,
    input  logic                wr_en_evict_way,

    // write data, shared by all ways
    input  llc_tag_t            wr_data_tag,
    input  line_t               wr_data_line,
    input  llc_state_t          wr_data_state,
    input  logic                wr_data_dirty_bit,
    input  sharers_t            wr_data_sharers,
    input  llc_way_t            wr_data_evict_way,

    // read data, one entry per way
    output llc_tag_t            rd_data_tag [LLC_WAYS],
    output line_t               rd_data_line [LLC_WAYS],
    output llc_state_t          rd_data_state [LLC_WAYS],
    output logic                rd_data_dirty_bit [LLC_WAYS],
    output sharers_t            rd_data_sharers [LLC_WAYS],

    // per-set replacement pointer
    output llc_way_t            rd_data_evict_way
);

    // every way sees the same set and data, the way index picks the writer
    for (genvar w = 0; w < LLC_WAYS; w++) begin : g_way
        llc_way_store #(
            .WAY_INDEX(w)
        ) way_store_inst (
            .clk(clk),
            .rst_n(rst_n),
            .set_in(set_in),
            .way(way),
            .wr_en(wr_en),
            .flush(wr_rst_flush[w]),
            .rd_en(rd_en),
            .wr_data_tag(wr_data_tag),
            .wr_data_line(wr_data_line),
            .wr_data_state(wr_data_state),
            .wr_data_dirty_bit(wr_data_dirty_bit),
            .wr_data_sharers(wr_data_sharers),
            .rd_data_tag(rd_data_tag[w]),
            .rd_data_line(rd_data_line[w]),
            .rd_data_state(rd_data_state[w]),
            .rd_data_dirty_bit(rd_data_dirty_bit[w]),
            .rd_data_sharers(rd_data_sharers[w])
        );
    end

    // one eviction pointer per set, written on its own strobe
    llc_sync_ram #(
        .WIDTH(LLC_WAY_BITS),
        .DEPTH_BITS(LLC_SET_BITS)
    ) evict_ram_inst (
        .clk(clk),
        .rst_n(rst_n),
        .we(wr_en_evict_way),
        .waddr(set_in),
        .wdata(wr_data_evict_way),
        .re(rd_en),
        .raddr(set_in),
        .rdata(rd_data_evict_way)
    );

    // the set index feeds every RAM, so it must be clean on any access
    a_set_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rd_en | wr_en | wr_en_evict_way | (|wr_rst_flush)) |->
            !$isunknown(set_in)
    ) else $error("llc_localmem: set_in unknown during an access");

endmodule

`default_nettype wire

// ==== tb/llc_tb_tasks.svh ====
`ifndef LLC_TB_TASKS_SVH
`define LLC_TB_TASKS_SVH

// reference model, one entry per way and set
llc_tag_t   m_tag [LLC_WAYS][LLC_SETS];
line_t      m_line [LLC_WAYS][LLC_SETS];
llc_state_t m_state [LLC_WAYS][LLC_SETS];
logic       m_dirty [LLC_WAYS][LLC_SETS];
sharers_t   m_sharers [LLC_WAYS][LLC_SETS];
llc_way_t   m_evict [LLC_SETS];

// what the outputs should show after the last read
int         exp_set;
llc_tag_t   exp_tag [LLC_WAYS];
line_t      exp_line [LLC_WAYS];
llc_state_t exp_state [LLC_WAYS];
logic       exp_dirty [LLC_WAYS];
sharers_t   exp_sharers [LLC_WAYS];
llc_way_t   exp_evict;

task automatic check_tag(input llc_tag_t got, input llc_tag_t want, input string what);
    if (got !== want) begin
        $display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, got, want);
        $display("STATUS: FAIL");
        $fatal(1, "tag mismatch");
    end
endtask

task automatic check_line(input line_t got, input line_t want, input string what);
    if (got !== want) begin
        $display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, got, want);
        $display("STATUS: FAIL");
        $fatal(1, "line mismatch");
    end
endtask

task automatic check_state(input llc_state_t got, input llc_state_t want, input string what);
    if (got !== want) begin
        $display("CHECK FAILED at %0t: %s read %0d, expected %0d", $time, what, got, want);
        $display("STATUS: FAIL");
        $fatal(1, "state mismatch");
    end
endtask

task automatic check_dirty(input logic got, input logic want, input string what);
    if (got !== want) begin
        $display("CHECK FAILED at %0t: %s read %b, expected %b", $time, what, got, want);
        $display("STATUS: FAIL");
        $fatal(1, "dirty bit mismatch");
    end
endtask

task automatic check_sharers(input sharers_t got, input sharers_t want, input string what);
    if (got !== want) begin
        $display("CHECK FAILED at %0t: %s read %b, expected %b", $time, what, got, want);
        $display("STATUS: FAIL");
        $fatal(1, "sharers mismatch");
    end
endtask

task automatic check_evict_way(input llc_way_t got, input llc_way_t want, input string what);
    if (got !== want) begin
        $display("CHECK FAILED at %0t: %s read %0d, expected %0d", $time, what, got, want);
        $display("STATUS: FAIL");
        $fatal(1, "eviction way mismatch");
    end
endtask

task automatic load_expected(input llc_set_t s);
    exp_set = int'(s);
    for (int w = 0; w < LLC_WAYS; w++) begin
        exp_tag[w] = m_tag[w][s];
        exp_line[w] = m_line[w][s];
        exp_state[w] = m_state[w][s];
        exp_dirty[w] = m_dirty[w][s];
        exp_sharers[w] = m_sharers[w][s];
    end
    exp_evict = m_evict[s];
endtask

task automatic check_outputs();
    for (int w = 0; w < LLC_WAYS; w++) begin
        check_tag(rd_data_tag[w], exp_tag[w], $sformatf("set %0d way %0d tag", exp_set, w));
        check_line(rd_data_line[w], exp_line[w], $sformatf("set %0d way %0d line", exp_set, w));
        check_state(rd_data_state[w], exp_state[w],
                    $sformatf("set %0d way %0d state", exp_set, w));
        check_dirty(rd_data_dirty_bit[w], exp_dirty[w],
                    $sformatf("set %0d way %0d dirty", exp_set, w));
        check_sharers(rd_data_sharers[w], exp_sharers[w],
                      $sformatf("set %0d way %0d sharers", exp_set, w));
    end
    check_evict_way(rd_data_evict_way, exp_evict, $sformatf("set %0d evict way", exp_set));
endtask

// full write to the selected way, flushable fields to flushed other ways
task automatic update_model(
    input llc_set_t s, input llc_way_t w, input logic we, input flush_t fl,
    input logic ev_we, input llc_tag_t tag, input line_t line, input llc_state_t st,
    input logic dirty, input sharers_t sh, input llc_way_t ev
);
    for (int i = 0; i < LLC_WAYS; i++) begin
        if (we && w == llc_way_t'(i)) begin
            m_tag[i][s] = tag;
            m_line[i][s] = line;
        end
        if ((we && w == llc_way_t'(i)) || (fl[i] && w != llc_way_t'(i))) begin
            m_state[i][s] = st;
            m_dirty[i][s] = dirty;
            m_sharers[i][s] = sh;
        end
    end
    if (ev_we) begin
        m_evict[s] = ev;
    end
endtask

task automatic idle_strobes();
    rd_en = 1'b0;
    wr_en = 1'b0;
    wr_rst_flush = '0;
    wr_en_evict_way = 1'b0;
endtask

// one access, starting 1 ns after a rising edge
task automatic drive_op(
    input llc_set_t s, input llc_way_t w, input logic we, input flush_t fl,
    input logic ev_we, input llc_tag_t tag, input line_t line, input llc_state_t st,
    input logic dirty, input sharers_t sh, input llc_way_t ev, input logic rd
);
    set_in = s;
    way = w;
    wr_en = we;
    wr_rst_flush = fl;
    wr_en_evict_way = ev_we;
    wr_data_tag = tag;
    wr_data_line = line;
    wr_data_state = st;
    wr_data_dirty_bit = dirty;
    wr_data_sharers = sh;
    wr_data_evict_way = ev;
    rd_en = rd;
    // a read on the same edge sees the contents before the write
    if (rd) begin
        load_expected(s);
    end
    @(posedge clk);
    #1;
    idle_strobes();
    if (rd) begin
        check_outputs();
    end
    update_model(s, w, we, fl, ev_we, tag, line, st, dirty, sh, ev);
endtask

task automatic read_set(input llc_set_t s);
    set_in = s;
    rd_en = 1'b1;
    load_expected(s);
    @(posedge clk);
    #1;
    idle_strobes();
    check_outputs();
endtask

`endif

// ==== tb/tb_llc_localmem.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_llc_localmem
    import llc_pkg::*;
();

    // tests need about 550 cycles including reset
    localparam int TIMEOUT_CYCLES = 2000;

    typedef logic [LLC_WAYS-1:0] flush_t;

    logic       clk;
    logic       rst_n;
    llc_set_t   set_in;
    llc_way_t   way;
    logic       rd_en;
    logic       wr_en;
    flush_t     wr_rst_flush;
    logic       wr_en_evict_way;
    llc_tag_t   wr_data_tag;
    line_t      wr_data_line;
    llc_state_t wr_data_state;
    logic       wr_data_dirty_bit;
    sharers_t   wr_data_sharers;
    llc_way_t   wr_data_evict_way;
    llc_tag_t   rd_data_tag [LLC_WAYS];
    line_t      rd_data_line [LLC_WAYS];
    llc_state_t rd_data_state [LLC_WAYS];
    logic       rd_data_dirty_bit [LLC_WAYS];
    sharers_t   rd_data_sharers [LLC_WAYS];
    llc_way_t   rd_data_evict_way;

    int          cycle_count;
    logic [15:0] lfsr_state;

    `include "llc_tb_tasks.svh"

    llc_localmem llc_localmem_inst (
        .clk(clk),
        .rst_n(rst_n),
        .set_in(set_in),
        .way(way),
        .rd_en(rd_en),
        .wr_en(wr_en),
        .wr_rst_flush(wr_rst_flush),
        .wr_en_evict_way(wr_en_evict_way),
        .wr_data_tag(wr_data_tag),
        .wr_data_line(wr_data_line),
        .wr_data_state(wr_data_state),
        .wr_data_dirty_bit(wr_data_dirty_bit),
        .wr_data_sharers(wr_data_sharers),
        .wr_data_evict_way(wr_data_evict_way),
        .rd_data_tag(rd_data_tag),
        .rd_data_line(rd_data_line),
        .rd_data_state(rd_data_state),
        .rd_data_dirty_bit(rd_data_dirty_bit),
        .rd_data_sharers(rd_data_sharers),
        .rd_data_evict_way(rd_data_evict_way)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: simulation timed out after %0d cycles", cycle_count);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    // galois lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_step();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 16'hb400;
        end
        return out_bit;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_step()};
        end
        return v;
    endfunction

    // folds 5..7 back onto legal encodings
    function automatic llc_state_t rand_state();
        logic [2:0] v;
        v = 3'(rand_bits(3));
        if (v > 3'd4) begin
            v = v - 3'd4;
        end
        return llc_state_t'(v);
    endfunction

    task automatic test_reset_values();
        exp_set = 0;
        for (int w = 0; w < LLC_WAYS; w++) begin
            exp_tag[w] = '0;
            exp_line[w] = '0;
            exp_state[w] = LLC_INVALID;
            exp_dirty[w] = 1'b0;
            exp_sharers[w] = '0;
        end
        exp_evict = '0;
        check_outputs();
    endtask

    // memory is not reset, so give every entry a known value
    task automatic init_memory();
        for (int s = 0; s < LLC_SETS; s++) begin
            for (int w = 0; w < LLC_WAYS; w++) begin
                drive_op(llc_set_t'(s), llc_way_t'(w), 1'b1, '0, (w == 0), '0, '0,
                         LLC_INVALID, 1'b0, '0, '0, 1'b0);
            end
        end
    endtask

    task automatic test_way_isolation();
        for (int i = 0; i < 4; i++) begin
            for (int w = 0; w < LLC_WAYS; w++) begin
                drive_op(llc_set_t'(4 * i + 3), llc_way_t'(w), 1'b1, '0, 1'b0,
                         {4'(4 * i + 3), 2'(w), 6'h15}, {8{4'(4 * i + 3), 2'(w), 2'b10}},
                         llc_state_t'(3'(w + 1)), 1'(w + i), sharers_t'(4'(i) ^ 4'(w + 5)),
                         '0, 1'b0);
            end
        end
        for (int i = 0; i < 4; i++) begin
            read_set(llc_set_t'(4 * i + 3));
        end
        // untouched set keeps its init values
        read_set(4'd0);
    endtask

    task automatic test_flush_write();
        drive_op(4'd7, 2'd1, 1'b1, 4'b1001, 1'b0, 12'h5a5, 64'hdead_beef_0123_4567,
                 LLC_MODIFIED, 1'b1, 4'b0110, 2'd0, 1'b0);
        read_set(4'd7);
        // flush bit of the selected way is ignored without wr_en
        drive_op(4'd11, 2'd2, 1'b0, 4'b0100, 1'b0, 12'h0f0, 64'h1111_2222_3333_4444,
                 LLC_SHARED, 1'b1, 4'b1111, 2'd0, 1'b0);
        read_set(4'd11);
        drive_op(4'd11, 2'd2, 1'b0, 4'b1111, 1'b0, 12'h0f0, 64'h1111_2222_3333_4444,
                 LLC_INVALID, 1'b0, 4'b0000, 2'd0, 1'b0);
        read_set(4'd11);
    endtask

    task automatic test_evict_pointer();
        for (int i = 0; i < 4; i++) begin
            drive_op(llc_set_t'(3 * i + 2), '0, 1'b0, '0, 1'b1, 12'hfff, '1,
                     LLC_MODIFIED, 1'b1, 4'hf, llc_way_t'(3 - i % 3), 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            read_set(llc_set_t'(3 * i + 2));
        end
    endtask

    task automatic test_read_first_and_hold();
        drive_op(4'd15, 2'd3, 1'b1, 4'b0001, 1'b1, 12'habc, 64'hcafe_f00d_0000_ffff,
                 LLC_EXCLUSIVE, 1'b0, 4'b1010, 2'd2, 1'b1);
        read_set(4'd15);
        read_set(4'd3);
        // outputs keep showing set 3 while it is rewritten
        drive_op(4'd3, 2'd0, 1'b1, 4'b1110, 1'b1, 12'h321, 64'h0123_4567_89ab_cdef,
                 LLC_VALID, 1'b1, 4'b0011, 2'd1, 1'b0);
        drive_op(4'd3, 2'd2, 1'b1, 4'b0000, 1'b0, 12'h654, 64'hfedc_ba98_7654_3210,
                 LLC_SHARED, 1'b0, 4'b1100, 2'd3, 1'b0);
        check_outputs();
        read_set(4'd3);
    endtask

    task automatic test_random_ops(input int count);
        llc_set_t s;
        for (int i = 0; i < count; i++) begin
            s = llc_set_t'(rand_bits(LLC_SET_BITS));
            drive_op(s, llc_way_t'(rand_bits(LLC_WAY_BITS)), 1'(rand_bits(1)),
                     flush_t'(rand_bits(LLC_WAYS)), 1'(rand_bits(1)),
                     llc_tag_t'(rand_bits(LLC_TAG_BITS)), line_t'(rand_bits(LLC_LINE_BITS)),
                     rand_state(), 1'(rand_bits(1)), sharers_t'(rand_bits(LLC_SHARERS_BITS)),
                     llc_way_t'(rand_bits(LLC_WAY_BITS)), 1'(rand_bits(1)));
            read_set(s);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        cycle_count = 0;
        lfsr_state = 16'd28;
        set_in = '0;
        way = '0;
        wr_data_tag = '0;
        wr_data_line = '0;
        wr_data_state = LLC_INVALID;
        wr_data_dirty_bit = 1'b0;
        wr_data_sharers = '0;
        wr_data_evict_way = '0;
        idle_strobes();

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_values();
        init_memory();
        test_way_isolation();
        test_flush_write();
        test_evict_pointer();
        test_read_first_and_hold();
        test_random_ops(200);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== llc_localmem.f ====
+incdir+tb
source/llc_pkg.sv
source/llc_sync_ram.sv
source/llc_way_store.sv
source/llc_localmem.sv
tb/tb_llc_localmem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_llc_localmem \
    -f llc_localmem.f -o tb_llc_localmem || exit 1
sim_out=$(./obj_dir/tb_llc_localmem)
echo "$sim_out"
echo "$sim_out" | grep -qx "STATUS: PASS" && echo "run_sim: passed" \
    || { echo "run_sim: failed"; exit 1; }
